/* verilog.f */
hw/bpu_pkg.sv
hw/bpu_table.sv
hw/bpu_decode.sv
hw/bpu_ras.sv
hw/bpu_csr.sv
hw/bpu_predict.sv
hw/bpu_top.sv
verif/bpu_assertions.sv
verif/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bpu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module bpu_tb -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    exit 0
fi
exit 1

/* verif/bpu_tb.sv */
`timescale 1ns/1ps

module bpu_tb;

    localparam int k_branch = 0;
    localparam int k_jal    = 1;
    localparam int k_jalr   = 2;
    localparam int k_ret    = 3;
    // per-test cycle budgets plus reset and margin
    localparam int budget_cycles = 40 + 120 + 80 + 240 + 120 + 100;

    logic                     clk;
    logic                     rst;
    bpu_pkg::fetch_t          fetch;
    bpu_pkg::resolve_t        resolve;
    bpu_pkg::wb_req_t         wb_req;
    bpu_pkg::pred_t           pred;
    logic [bpu_pkg::hist_width-1:0] history;
    bpu_pkg::wb_rsp_t         wb_rsp;

    // reference model state
    bpu_pkg::ctr_t            m_ctr [bpu_pkg::bim_entries];
    bpu_pkg::btb_entry_t      m_btb [bpu_pkg::btb_entries];
    logic [31:0]              m_ras [$];
    logic [bpu_pkg::hist_width-1:0] m_hist;
    bpu_pkg::ctrl_t           m_ctrl;
    int                       m_total;
    int                       m_miss;
    int                       errors = 0;
    logic [31:0]              rng_state = 32'hb7cda0ab;

    bpu_top UUT (
        .clk(clk), .rst(rst), .fetch_i(fetch), .resolve_i(resolve), .wb_i(wb_req),
        .pred_o(pred), .history_o(history), .wb_o(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(budget_cycles * 20);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] rand_pc();
        return xorshift32() & 32'hffff_fffc;   // word aligned
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], bpu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, bpu_pkg::op_jal};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, bpu_pkg::op_jalr};
    endfunction

    function automatic logic [8:0] bim_index(input logic [31:0] pc, input logic [8:0] h);
        return pc[10:2] ^ (m_ctrl.gshare_en ? h : 9'd0);
    endfunction

    // expected prediction from the model state
    function automatic bpu_pkg::pred_t model_pred(input int kind, input logic [31:0] pc,
                                                  input logic [31:0] off);
        bpu_pkg::pred_t      p;
        bpu_pkg::btb_entry_t e;
        logic                hit;
        e = m_btb[pc[9:2]];
        hit = m_ctrl.btb_en && e.valid && (e.tag == pc[31:10]);
        p.is_ctrl = 1'b1;
        p.taken   = 1'b0;
        p.target  = pc + 32'd4;
        if (m_ctrl.pred_en) begin
            if (kind == k_ret) begin
                if (m_ctrl.ras_en && m_ras.size() > 0) begin
                    p.taken  = 1'b1;
                    p.target = m_ras[$];
                end
            end else if (kind == k_jal) begin
                p.taken  = 1'b1;
                p.target = hit ? e.target : pc + off;
            end else if (kind == k_jalr) begin
                p.taken  = hit;
                p.target = hit ? e.target : pc + 32'd4;
            end else if (m_ctr[bim_index(pc, m_hist)][1]) begin
                p.taken  = 1'b1;
                p.target = hit ? e.target : pc + off;
            end
        end
        return p;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        bpu_pkg::wb_req_t r;
        int               waits;
        r = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
        waits = 0;
        @(posedge clk);
        wb_req <= r;
        do begin
            @(negedge clk);
            waits++;
        end while (!wb_rsp.ack && waits < 8);
        if (!wb_rsp.ack) begin
            $display("no wishbone ack for address %h", adr);
            errors++;
        end else begin
            check("wb_ack_latency", 32'd2, waits);   // ack one clock after the request
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;   // drop stb the cycle after ack
    endtask

    task automatic set_ctrl(input bpu_pkg::ctrl_t v);
        logic [31:0] d;
        wb_access(1'b1, bpu_pkg::csr_ctrl_addr, {28'd0, v}, d);
        m_ctrl = v;
    endtask

    task automatic read_check(input string name, input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] d;
        wb_access(1'b0, adr, 32'd0, d);
        check(name, exp, d);
    endtask

    task automatic predict_check(input string name, input logic [31:0] pc, input logic [31:0] inst,
                                 input int kind, input logic [31:0] off);
        bpu_pkg::fetch_t f;
        f.pc   = pc;
        f.inst = inst;
        @(posedge clk);
        fetch <= f;
        @(negedge clk);
        check(name, model_pred(kind, pc, off), pred);
        check(name, m_hist, history);
    endtask

    // one resolve report, model updated alongside
    task automatic resolve_one(input logic [31:0] pc, input logic [31:0] inst, input int kind,
                               input logic call, input logic [31:0] off, input logic taken,
                               input logic [31:0] target);
        bpu_pkg::resolve_t r;
        bpu_pkg::pred_t    p;
        logic [8:0]        idx;
        p = model_pred(kind, pc, off);
        r = '{valid: 1'b1, taken: taken,
              correct: (p.taken == taken) && (!taken || p.target == target),
              pc: pc, inst: inst, target: target, history: m_hist};
        @(posedge clk);
        resolve <= r;
        m_total++;
        if (!r.correct) m_miss++;
        if (kind == k_branch) begin
            idx = bim_index(pc, m_hist);
            if (taken && m_ctr[idx] != 2'b11) m_ctr[idx] = m_ctr[idx] + 2'd1;
            else if (!taken && m_ctr[idx] != 2'b00) m_ctr[idx] = m_ctr[idx] - 2'd1;
            m_hist = {m_hist[7:0], taken};
        end
        if (taken) m_btb[pc[9:2]] = '{valid: 1'b1, tag: pc[31:10], target: target};
        if (call && m_ras.size() < bpu_pkg::ras_depth) m_ras.push_back(pc + 32'd4);
        if (kind == k_ret && m_ras.size() > 0) void'(m_ras.pop_back());
        @(posedge clk);
        resolve.valid <= 1'b0;
    endtask

    task automatic test_reset();
        logic [31:0] pc;
        pc = rand_pc();
        read_check("reset_ctrl", bpu_pkg::csr_ctrl_addr, {28'd0, bpu_pkg::ctrl_reset});
        read_check("reset_total", bpu_pkg::csr_total_addr, 32'd0);
        read_check("reset_miss", bpu_pkg::csr_miss_addr, 32'd0);
        check("reset_hist", 9'd0, history);
        predict_check("reset_branch", pc, enc_branch(13'h40), k_branch, 32'h40);
        check("reset_branch", {1'b1, 1'b0, pc + 32'd4}, pred);
    endtask

    task automatic direction_pass(input string name);
        logic [31:0] pc;
        logic [31:0] off;
        logic [31:0] inst;
        pc   = rand_pc();
        off  = 32'hffff_ffc0;   // backward branch
        inst = enc_branch(off[12:0]);
        predict_check(name, pc, inst, k_branch, off);
        repeat (2) begin
            resolve_one(pc, inst, k_branch, 1'b0, off, 1'b1, pc + off);
            predict_check(name, pc, inst, k_branch, off);
        end
        if (!m_ctrl.gshare_en) check(name, {1'b1, pc + off}, {pred.taken, pred.target});
        repeat (2) begin
            resolve_one(pc, inst, k_branch, 1'b0, off, 1'b0, pc + 32'd4);
            predict_check(name, pc, inst, k_branch, off);
        end
        if (!m_ctrl.gshare_en) check(name, 1'b0, pred.taken);
    endtask

    task automatic test_direction();
        set_ctrl(4'b1110);
        direction_pass("dir_bimodal");
        set_ctrl(4'b1111);
        direction_pass("dir_gshare");
    endtask

    task automatic test_btb();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] tgt;
        pc   = rand_pc();
        tgt  = rand_pc();
        inst = enc_jal(5'd0, 21'h1f48);
        predict_check("btb_cold", pc, inst, k_jal, 32'h1f48);
        check("btb_cold", pc + 32'h1f48, pred.target);
        resolve_one(pc, inst, k_jal, 1'b0, 32'h1f48, 1'b1, tgt);
        predict_check("btb_hit", pc, inst, k_jal, 32'h1f48);
        check("btb_hit", tgt, pred.target);
        set_ctrl(4'b1011);
        predict_check("btb_off", pc, inst, k_jal, 32'h1f48);
        set_ctrl(4'b1111);
        pc = rand_pc();
        predict_check("btb_jalr", pc, enc_jalr(5'd0, 5'd6), k_jalr, 32'd0);
        check("btb_jalr", 1'b0, pred.taken);
    endtask

    task automatic test_ras();
        logic [31:0] pa;
        logic [31:0] pb;
        logic [31:0] pr;
        logic [31:0] ret;
        logic [31:0] pcs [17];
        pa  = rand_pc();
        pb  = rand_pc();
        pr  = rand_pc();
        ret = enc_jalr(5'd0, bpu_pkg::reg_ra);
        resolve_one(pa, enc_jal(bpu_pkg::reg_ra, 21'h200), k_jal, 1'b1, 32'h200, 1'b1, pa + 32'h200);
        resolve_one(pb, enc_jal(bpu_pkg::reg_t0, 21'h80), k_jal, 1'b1, 32'h80, 1'b1, pb + 32'h80);
        predict_check("ras_nested", pr, ret, k_ret, 32'd0);
        check("ras_nested", pb + 32'd4, pred.target);
        resolve_one(pr, ret, k_ret, 1'b0, 32'd0, 1'b1, pb + 32'd4);
        predict_check("ras_nested", pr, ret, k_ret, 32'd0);
        check("ras_nested", pa + 32'd4, pred.target);
        resolve_one(pr, ret, k_ret, 1'b0, 32'd0, 1'b1, pa + 32'd4);
        predict_check("ras_empty", pr, ret, k_ret, 32'd0);
        check("ras_empty", 1'b0, pred.taken);
        // one more push than the stack holds
        for (int i = 0; i < 17; i++) begin
            pcs[i] = rand_pc();
            resolve_one(pcs[i], enc_jal(bpu_pkg::reg_ra, 21'h100), k_jal, 1'b1, 32'h100, 1'b1,
                        pcs[i] + 32'h100);
        end
        for (int j = 15; j >= 0; j--) begin
            predict_check("ras_deep", pr, ret, k_ret, 32'd0);
            check("ras_deep", pcs[j] + 32'd4, pred.target);
            resolve_one(pr, ret, k_ret, 1'b0, 32'd0, 1'b1, pcs[j] + 32'd4);
        end
        predict_check("ras_drained", pr, ret, k_ret, 32'd0);
    endtask

    task automatic test_stats();
        logic [31:0] pc;
        logic [31:0] bi;
        pc = rand_pc();
        bi = enc_branch(13'h24);
        resolve_one(pc, bi, k_branch, 1'b0, 32'h24, 1'b1, pc + 32'h24);
        resolve_one(pc, bi, k_branch, 1'b0, 32'h24, 1'b0, pc + 32'd4);
        resolve_one(pc, enc_jal(5'd0, 21'h400), k_jal, 1'b0, 32'h400, 1'b1, pc + 32'h400);
        read_check("stats_total", bpu_pkg::csr_total_addr, m_total);
        read_check("stats_miss", bpu_pkg::csr_miss_addr, m_miss);
        wb_access(1'b1, bpu_pkg::csr_total_addr, 32'h5a5a_0001, pc);
        wb_access(1'b1, bpu_pkg::csr_miss_addr, 32'h5a5a_0002, pc);
        read_check("stats_ro_total", bpu_pkg::csr_total_addr, m_total);
        read_check("stats_ro_miss", bpu_pkg::csr_miss_addr, m_miss);
        read_check("stats_ro_ctrl", bpu_pkg::csr_ctrl_addr, {28'd0, m_ctrl});
        read_check("stats_unmapped", 4'hc, 32'd0);
        set_ctrl(4'b0111);
        pc = rand_pc();
        predict_check("pred_off", pc, enc_jal(5'd0, 21'h400), k_jal, 32'h400);
        check("pred_off", {1'b1, 1'b0, pc + 32'd4}, pred);
    endtask

    initial begin
        rst     = 1'b1;
        fetch   = '0;
        resolve = '0;
        wb_req  = '0;
        m_hist  = '0;
        m_ctrl  = bpu_pkg::ctrl_reset;
        m_total = 0;
        m_miss  = 0;
        foreach (m_ctr[i]) m_ctr[i] = bpu_pkg::ctr_weak_not_taken;
        foreach (m_btb[i]) m_btb[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_direction();
        test_btb();
        test_ras();
        test_stats();
        repeat (2) @(posedge clk);
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/bpu_assertions.sv */
`timescale 1ns/1ps

module bpu_assertions (
    input logic             clk,
    input logic             rst,
    input bpu_pkg::wb_req_t wb_i,
    input bpu_pkg::wb_rsp_t wb_o,
    input bpu_pkg::pred_t   pred_o
);

    // ack only answers a request seen one cycle earlier
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_o.ack |-> $past(wb_i.cyc && wb_i.stb))
        else $error("wishbone ack without a preceding request");

    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_o.ack |=> !wb_o.ack)
        else $error("wishbone ack held for two cycles");

    taken_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_o.taken |-> pred_o.is_ctrl)
        else $error("taken prediction for a non-control instruction");

endmodule

bind bpu_top bpu_assertions u_assertions (
    .clk(clk), .rst(rst), .wb_i(wb_i), .wb_o(wb_o), .pred_o(pred_o)
);

/* hw/bpu_top.sv */
`timescale 1ns/1ps

module bpu_top (
    input  logic                           clk,
    input  logic                           rst,
    input  bpu_pkg::fetch_t                fetch_i,
    input  bpu_pkg::resolve_t              resolve_i,
    input  bpu_pkg::wb_req_t               wb_i,
    output bpu_pkg::pred_t                 pred_o,
    output logic [bpu_pkg::hist_width-1:0] history_o,
    output bpu_pkg::wb_rsp_t               wb_o
);

    bpu_pkg::ctrl_t ctrl;   // enables from the control register

    // prediction path, same-cycle from fetch
    bpu_predict u_predict (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch_i),
        .resolve_i (resolve_i),
        .ctrl_i    (ctrl),
        .pred_o    (pred_o),
        .history_o (history_o)
    );

    // wishbone configuration and statistics
    bpu_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .wb_i      (wb_i),
        .resolve_i (resolve_i),
        .wb_o      (wb_o),
        .ctrl_o    (ctrl)
    );

endmodule

/* hw/bpu_predict.sv */
`timescale 1ns/1ps

module bpu_predict (
    input  logic                           clk,
    input  logic                           rst,
    input  bpu_pkg::fetch_t                fetch_i,
    input  bpu_pkg::resolve_t              resolve_i,
    input  bpu_pkg::ctrl_t                 ctrl_i,
    output bpu_pkg::pred_t                 pred_o,
    output logic [bpu_pkg::hist_width-1:0] history_o
);

    bpu_pkg::inst_class_t                 f_cls;
    bpu_pkg::inst_class_t                 r_cls;
    logic [bpu_pkg::hist_width-1:0]       hist_q;

    logic [bpu_pkg::bim_idx_width-1:0]    f_bim_idx;
    logic [bpu_pkg::bim_idx_width-1:0]    r_bim_idx;
    bpu_pkg::ctr_t                        f_ctr;
    bpu_pkg::ctr_t                        r_ctr;
    bpu_pkg::ctr_t                        r_ctr_next;
    logic                                 ctr_we;

    logic [bpu_pkg::btb_idx_width-1:0]    f_btb_idx;
    logic [bpu_pkg::btb_idx_width-1:0]    r_btb_idx;
    bpu_pkg::btb_entry_t                  f_btb;
    bpu_pkg::btb_entry_t                  r_btb;
    bpu_pkg::btb_entry_t                  r_btb_new;
    logic                                 btb_hit;
    logic                                 btb_we;

    logic [bpu_pkg::xlen-1:0]             ras_top;
    logic                                 ras_empty;
    logic                                 r_is_ctrl;

    bpu_decode u_fetch_dec (.inst_i(fetch_i.inst),   .class_o(f_cls));
    bpu_decode u_res_dec   (.inst_i(resolve_i.inst), .class_o(r_cls));

    // gshare index, history folded in only when enabled
    assign f_bim_idx = fetch_i.pc[bpu_pkg::bim_idx_width+1:2]
                     ^ (ctrl_i.gshare_en ? hist_q : '0);
    assign r_bim_idx = resolve_i.pc[bpu_pkg::bim_idx_width+1:2]
                     ^ (ctrl_i.gshare_en ? resolve_i.history : '0);

    assign f_btb_idx = fetch_i.pc[bpu_pkg::btb_idx_width+1:2];
    assign r_btb_idx = resolve_i.pc[bpu_pkg::btb_idx_width+1:2];

    assign btb_hit = ctrl_i.btb_en && f_btb.valid
                  && (f_btb.tag == fetch_i.pc[bpu_pkg::xlen-1:bpu_pkg::btb_idx_width+2]);

    // saturating step toward the outcome
    always_comb begin
        r_ctr_next = r_ctr;
        if (resolve_i.taken && (r_ctr != 2'b11)) begin
            r_ctr_next = r_ctr + 1'b1;
        end else if (!resolve_i.taken && (r_ctr != 2'b00)) begin
            r_ctr_next = r_ctr - 1'b1;
        end
    end

    assign ctr_we    = resolve_i.valid && r_cls.is_branch;
    assign r_is_ctrl = r_cls.is_branch || r_cls.is_jal || r_cls.is_jalr;

    assign r_btb_new.valid  = 1'b1;
    assign r_btb_new.tag    = resolve_i.pc[bpu_pkg::xlen-1:bpu_pkg::btb_idx_width+2];
    assign r_btb_new.target = resolve_i.target;
    assign btb_we = resolve_i.valid && resolve_i.taken && r_is_ctrl
                 && (r_btb != r_btb_new);   // skip rewriting an identical entry

    bpu_table #(
        .entry_t(bpu_pkg::ctr_t),
        .entries(bpu_pkg::bim_entries),
        .reset_value(bpu_pkg::ctr_weak_not_taken)
    ) u_bim (
        .clk(clk), .rst(rst),
        .rd_a_idx_i(f_bim_idx), .rd_b_idx_i(r_bim_idx),
        .rd_a_o(f_ctr), .rd_b_o(r_ctr),
        .we_i(ctr_we), .wr_idx_i(r_bim_idx), .wr_data_i(r_ctr_next)
    );

    bpu_table #(
        .entry_t(bpu_pkg::btb_entry_t),
        .entries(bpu_pkg::btb_entries),
        .reset_value('0)
    ) u_btb (
        .clk(clk), .rst(rst),
        .rd_a_idx_i(f_btb_idx), .rd_b_idx_i(r_btb_idx),
        .rd_a_o(f_btb), .rd_b_o(r_btb),
        .we_i(btb_we), .wr_idx_i(r_btb_idx), .wr_data_i(r_btb_new)
    );

    bpu_ras u_ras (
        .clk(clk), .rst(rst),
        .push_i(resolve_i.valid && r_cls.is_call),
        .push_addr_i(resolve_i.pc + 32'd4),
        .pop_i(resolve_i.valid && r_cls.is_ret),
        .top_o(ras_top), .empty_o(ras_empty)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ctr_we) begin
            hist_q <= {hist_q[bpu_pkg::hist_width-2:0], resolve_i.taken};
        end
    end

    assign history_o = hist_q;

    always_comb begin
        pred_o.is_ctrl = f_cls.is_branch || f_cls.is_jal || f_cls.is_jalr;
        pred_o.taken   = 1'b0;
        pred_o.target  = fetch_i.pc + 32'd4;
        if (ctrl_i.pred_en) begin
            if (f_cls.is_ret) begin
                if (ctrl_i.ras_en && !ras_empty) begin
                    pred_o.taken  = 1'b1;
                    pred_o.target = ras_top;
                end
            end else if (f_cls.is_jal) begin
                pred_o.taken  = 1'b1;
                pred_o.target = btb_hit ? f_btb.target : fetch_i.pc + f_cls.j_offset;
            end else if (f_cls.is_jalr) begin
                if (btb_hit) begin           // indirect needs a btb hit
                    pred_o.taken  = 1'b1;
                    pred_o.target = f_btb.target;
                end
            end else if (f_cls.is_branch && f_ctr[1]) begin
                pred_o.taken  = 1'b1;
                pred_o.target = btb_hit ? f_btb.target : fetch_i.pc + f_cls.b_offset;
            end
        end
    end

endmodule

/* hw/bpu_csr.sv */
`timescale 1ns/1ps

module bpu_csr (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::wb_req_t   wb_i,
    input  bpu_pkg::resolve_t  resolve_i,
    output bpu_pkg::wb_rsp_t   wb_o,
    output bpu_pkg::ctrl_t     ctrl_o
);

    bpu_pkg::ctrl_t            ctrl_q;
    logic [bpu_pkg::xlen-1:0]  total_q;    // resolved branches
    logic [bpu_pkg::xlen-1:0]  miss_q;     // mispredictions
    logic                      ack_q;
    logic [31:0]               rdata_q;
    logic                      req;
    logic [31:0]               rdata_mux;

    // new request only while no ack is pending
    assign req = wb_i.cyc && wb_i.stb && !ack_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q   <= 1'b0;
            ctrl_q  <= bpu_pkg::ctrl_reset;
            total_q <= '0;
            miss_q  <= '0;
        end else begin
            ack_q <= req;

            // only the control register is writable
            if (req && wb_i.we && wb_i.sel[0] && (wb_i.adr == bpu_pkg::csr_ctrl_addr)) begin
                ctrl_q <= bpu_pkg::ctrl_t'(wb_i.dat[3:0]);
            end

            if (resolve_i.valid) begin
                total_q <= total_q + 1'b1;
                if (!resolve_i.correct) begin
                    miss_q <= miss_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (wb_i.adr)
            bpu_pkg::csr_ctrl_addr:  rdata_mux = {28'd0, ctrl_q};
            bpu_pkg::csr_total_addr: rdata_mux = total_q;
            bpu_pkg::csr_miss_addr:  rdata_mux = miss_q;
            default:                 rdata_mux = 32'd0;   // unmapped reads as zero
        endcase
    end

    // read data captured alongside the ack
    always_ff @(posedge clk) begin
        if (req) begin
            rdata_q <= rdata_mux;
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdata_q;
    assign ctrl_o   = ctrl_q;

endmodule

/* hw/bpu_ras.sv */
`timescale 1ns/1ps

module bpu_ras (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push_i,
    input  logic [bpu_pkg::xlen-1:0] push_addr_i,
    input  logic                     pop_i,
    output logic [bpu_pkg::xlen-1:0] top_o,
    output logic                     empty_o
);

    logic [bpu_pkg::xlen-1:0]            stack [bpu_pkg::ras_depth];
    logic [bpu_pkg::ras_ptr_width-1:0]   ptr_q;     // next free slot
    logic [bpu_pkg::ras_ptr_width-2:0]   wr_slot;
    logic [bpu_pkg::ras_ptr_width-2:0]   top_slot;
    logic                                full;

    assign full    = (ptr_q == bpu_pkg::ras_ptr_width'(bpu_pkg::ras_depth));
    assign empty_o = (ptr_q == '0);

    assign wr_slot  = ptr_q[bpu_pkg::ras_ptr_width-2:0];
    assign top_slot = wr_slot - 1'b1;   // wraps to 15 when full

    // pointer only, entries keep their contents
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (push_i && !full) begin
            ptr_q <= ptr_q + 1'b1;
        end else if (pop_i && !empty_o) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

    // push beyond depth is dropped
    always_ff @(posedge clk) begin
        if (push_i && !full) begin
            stack[wr_slot] <= push_addr_i;
        end
    end

    assign top_o = stack[top_slot];   // stale when empty, qualified by empty_o

endmodule

/* hw/bpu_decode.sv */
`timescale 1ns/1ps

module bpu_decode (
    input  logic [bpu_pkg::xlen-1:0] inst_i,
    output bpu_pkg::inst_class_t     class_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm_i;
    logic        rd_link;
    logic        rs1_link;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign imm_i  = inst_i[31:20];

    assign rd_link  = (rd == bpu_pkg::reg_ra) || (rd == bpu_pkg::reg_t0);
    assign rs1_link = (rs1 == bpu_pkg::reg_ra) || (rs1 == bpu_pkg::reg_t0);

    always_comb begin
        class_o.is_branch = (opcode == bpu_pkg::op_branch);
        class_o.is_jal    = (opcode == bpu_pkg::op_jal);
        class_o.is_jalr   = (opcode == bpu_pkg::op_jalr);

        // link register as rd marks a call
        class_o.is_call = (class_o.is_jal || class_o.is_jalr) && rd_link;

        // jalr x0, 0(ra or t0)
        class_o.is_ret = class_o.is_jalr && (rd == 5'd0) && rs1_link && (imm_i == 12'd0);

        // b-type immediate, bit 0 implied zero
        class_o.b_offset = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                            inst_i[30:25], inst_i[11:8], 1'b0};

        // j-type immediate
        class_o.j_offset = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                            inst_i[20], inst_i[30:21], 1'b0};
    end

endmodule

/* hw/bpu_table.sv */
`timescale 1ns/1ps

module bpu_table #(
    parameter type    entry_t     = logic [1:0],
    parameter int     entries     = 512,
    parameter entry_t reset_value = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [$clog2(entries)-1:0] rd_a_idx_i,
    input  logic [$clog2(entries)-1:0] rd_b_idx_i,
    output entry_t                     rd_a_o,
    output entry_t                     rd_b_o,
    input  logic                       we_i,
    input  logic [$clog2(entries)-1:0] wr_idx_i,
    input  entry_t                     wr_data_i
);

    entry_t mem [entries];

    // whole array returns to its reset value, single write port otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                mem[i] <= reset_value;
            end
        end else if (we_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // port a serves fetch, port b the resolve-side read-modify-write
    assign rd_a_o = mem[rd_a_idx_i];
    assign rd_b_o = mem[rd_b_idx_i];

endmodule

/* hw/bpu_pkg.sv */
package bpu_pkg;

    // datapath and table sizes
    localparam int xlen          = 32;
    localparam int hist_width    = 9;
    localparam int bim_entries   = 512;
    localparam int bim_idx_width = 9;
    localparam int btb_entries   = 256;
    localparam int btb_idx_width = 8;
    localparam int btb_tag_width = 22;   // pc[31:10]
    localparam int ras_depth     = 16;
    localparam int ras_ptr_width = 5;    // counts 0..16

    // rv32 opcodes and link registers
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [4:0] reg_ra    = 5'd1;
    localparam logic [4:0] reg_t0    = 5'd5;

    // wishbone register map, byte addresses of 32-bit words
    localparam int wb_addr_width = 4;
    localparam logic [wb_addr_width-1:0] csr_ctrl_addr  = 4'h0;
    localparam logic [wb_addr_width-1:0] csr_total_addr = 4'h4;
    localparam logic [wb_addr_width-1:0] csr_miss_addr  = 4'h8;

    typedef logic [1:0] ctr_t;
    localparam ctr_t ctr_weak_not_taken = 2'b01;

    typedef struct packed {
        logic                     valid;
        logic [btb_tag_width-1:0] tag;
        logic [xlen-1:0]          target;
    } btb_entry_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        logic                  taken;    // actual direction
        logic                  correct;  // earlier prediction matched
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       inst;
        logic [xlen-1:0]       target;   // actual target
        logic [hist_width-1:0] history;  // history seen at predict time
    } resolve_t;

    typedef struct packed {
        logic            is_ctrl;
        logic            taken;
        logic [xlen-1:0] target;
    } pred_t;

    // bit 3 down to bit 0 in the control register
    typedef struct packed {
        logic pred_en;
        logic btb_en;
        logic ras_en;
        logic gshare_en;
    } ctrl_t;

    localparam ctrl_t ctrl_reset = 4'b1111;

    typedef struct packed {
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            is_call;
        logic            is_ret;
        logic [xlen-1:0] b_offset;
        logic [xlen-1:0] j_offset;
    } inst_class_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [wb_addr_width-1:0] adr;
        logic [31:0]              dat;
        logic [3:0]               sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage
